// ==== Bender.yml ====
package:
  name: paclan_main

sources:
  - hdl/paclan_pkg.sv
  - hdl/paclan_addr_dec.sv
  - hdl/paclan_ctrl_regs.sv
  - hdl/paclan_watchdog.sv
  - hdl/paclan_busmux.sv
  - hdl/paclan_main.sv
  - target: simulation
    files:
      - testbench/paclan_main_tb.sv

// ==== hdl/paclan_addr_dec.sv ====
////////////////////////////////////////////////////////////
// Main CPU address decoder with the VBL interrupt, flip and
// sub-CPU reset latches. Selects are combinational from addr.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module paclan_addr_dec (
    input  logic                  clk,
    input  logic                  rst,
    input  paclan_pkg::main_bus_t bus,
    input  logic                  lvbl,
    output paclan_pkg::chip_sel_t cs,
    output logic                  int_n,
    output logic                  flip,
    output logic                  srst
);

    logic [15:0] addr;
    logic        oram_win;
    logic        irq_cs;
    logic        flip_cs;
    logic        srst_cs;
    logic        lvbl_l;
    logic        vb_fall;
    logic        irq_en;

    assign addr = bus.addr;

    // Memory and register selects
    assign cs.scr0 = paclan_pkg::addr_hit(addr, paclan_pkg::SCR0_BASE, paclan_pkg::SCR0_MASK);
    assign cs.scr1 = paclan_pkg::addr_hit(addr, paclan_pkg::SCR1_BASE, paclan_pkg::SCR1_MASK);
    assign oram_win = paclan_pkg::addr_hit(addr, paclan_pkg::ORAM_BASE, paclan_pkg::ORAM_MASK);
    assign cs.scr0pos = paclan_pkg::addr_hit(addr, paclan_pkg::SCR0POS_ADDR,
                                             paclan_pkg::SCR0POS_MASK);
    assign cs.scr1pos = paclan_pkg::addr_hit(addr, paclan_pkg::SCR1POS_ADDR,
                                             paclan_pkg::SCR1POS_MASK);
    assign cs.basel = paclan_pkg::addr_hit(addr, paclan_pkg::BASEL_ADDR,
                                           paclan_pkg::BASEL_MASK);
    // 3800-3FFF belongs to the registers
    assign cs.oram = oram_win & ~(cs.scr0pos | cs.scr1pos | cs.basel);
    assign cs.banked = paclan_pkg::addr_hit(addr, paclan_pkg::BANKED_BASE,
                                            paclan_pkg::BANKED_MASK);
    // Banked window is fetched from the ROM too
    assign cs.rom = cs.banked |
                    paclan_pkg::addr_hit(addr, paclan_pkg::ROM_BASE, paclan_pkg::ROM_MASK);
    assign cs.c30 = paclan_pkg::addr_hit(addr, paclan_pkg::C30_BASE, paclan_pkg::C30_MASK);

    // Write-only latches
    assign cs.wdog = ~bus.rnw &
                     paclan_pkg::addr_hit(addr, paclan_pkg::WDOG_ADDR, paclan_pkg::WDOG_MASK);
    assign irq_cs  = ~bus.rnw &
                     paclan_pkg::addr_hit(addr, paclan_pkg::IRQ_ADDR, paclan_pkg::IRQ_MASK);
    assign flip_cs = ~bus.rnw &
                     paclan_pkg::addr_hit(addr, paclan_pkg::FLIP_ADDR, paclan_pkg::FLIP_MASK);
    assign srst_cs = ~bus.rnw &
                     paclan_pkg::addr_hit(addr, paclan_pkg::SRST_ADDR, paclan_pkg::SRST_MASK);

    assign vb_fall = lvbl_l & ~lvbl;

    always_ff @(posedge clk) begin
        if (rst) begin
            lvbl_l <= 1'b0;
            irq_en <= 1'b0;
            int_n  <= 1'b1;
            flip   <= 1'b0;
            srst   <= 1'b0;
        end else begin
            lvbl_l <= lvbl;
            if (vb_fall && irq_en) begin
                int_n <= 1'b0;
            end
            // Acknowledge also rewrites the enable, and wins over a new edge
            if (bus.cen_e && irq_cs) begin
                int_n  <= 1'b1;
                irq_en <= addr[0];
            end
            if (bus.cen_e && flip_cs) begin
                flip <= addr[0];
            end
            // addr[0] low holds the sub CPU in reset
            if (bus.cen_e && srst_cs) begin
                srst <= ~addr[0];
            end
        end
    end

    // Only one memory may drive the CPU data bus
    a_one_mem_sel: assert property (@(posedge clk) disable iff (rst)
        $onehot0({cs.scr0, cs.scr1, cs.oram, cs.c30, cs.rom}));

endmodule

// ==== hdl/paclan_busmux.sv ====
////////////////////////////////////////////////////////////
// CPU read data multiplexer. Picks the byte of the selected
// source, FF when idle, and delays the ROM ready flag.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module paclan_busmux (
    input  logic                  clk,
    input  logic                  addr0,
    input  paclan_pkg::chip_sel_t cs,
    input  logic                  rom_ok,
    input  logic [15:0]           scr0_dout,
    input  logic [15:0]           scr1_dout,
    input  logic [15:0]           oram_dout,
    input  logic [ 7:0]           c30_dout,
    input  logic [ 7:0]           rom_data,
    output logic                  ok_dly,
    output logic [ 7:0]           cpu_din
);

    // Odd addresses read the upper byte of a 16-bit RAM
    function automatic logic [7:0] ram_byte(
        input logic [15:0] word,
        input logic        hi
    );
        return hi ? word[15:8] : word[7:0];
    endfunction

    always_comb begin
        cpu_din = 8'hFF;
        if (cs.rom) begin
            cpu_din = rom_data;
        end else if (cs.scr0) begin
            cpu_din = ram_byte(scr0_dout, addr0);
        end else if (cs.scr1) begin
            cpu_din = ram_byte(scr1_dout, addr0);
        end else if (cs.oram) begin
            cpu_din = ram_byte(oram_dout, addr0);
        end else if (cs.c30) begin
            cpu_din = c30_dout;
        end
    end

    // SDRAM ok is one cycle ahead of usable data
    always_ff @(posedge clk) begin
        ok_dly <= rom_ok;
    end

endmodule

// ==== hdl/paclan_ctrl_regs.sv ====
////////////////////////////////////////////////////////////
// Scroll position registers and the palette/ROM bank byte,
// loaded by strobed CPU writes under their selects.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module paclan_ctrl_regs (
    input  logic                  clk,
    input  logic                  rst,
    input  paclan_pkg::main_bus_t bus,
    input  paclan_pkg::chip_sel_t cs,
    output logic [8:0]            scr0_pos,
    output logic [8:0]            scr1_pos,
    output paclan_pkg::bank_reg_t bank_reg
);

    logic wr;

    assign wr = bus.cen_e & ~bus.rnw;

    always_ff @(posedge clk) begin
        if (rst) begin
            scr0_pos <= '0;
            scr1_pos <= '0;
            bank_reg <= '0;
        end else if (wr) begin
            // Scroll MSB comes from the address LSB
            if (cs.scr0pos) begin
                scr0_pos <= {bus.addr[0], bus.dout};
            end
            if (cs.scr1pos) begin
                scr1_pos <= {bus.addr[0], bus.dout};
            end
            if (cs.basel) begin
                bank_reg <= paclan_pkg::bank_reg_t'(bus.dout);
            end
        end
    end

    // Any register change must trace back to a strobed write
    a_strobed_update: assert property (@(posedge clk) disable iff (rst)
        !$stable({scr0_pos, scr1_pos, bank_reg}) |-> $past(bus.cen_e && !bus.rnw));

endmodule

// ==== hdl/paclan_main.sv ====
////////////////////////////////////////////////////////////
// Main CPU bus subsystem top level. Takes the CPU bus as a
// struct and returns selects, write enables and read data.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module paclan_main #(
    parameter int unsigned WDOG_FRAMES = 8,
    parameter int unsigned WDOG_PULSE  = 16
) (
    input  logic                          clk,
    input  logic                          rst,
    input  paclan_pkg::main_bus_t         bus,
    input  logic                          lvbl,
    input  logic                          rom_ok,
    input  logic [7:0]                    rom_data,
    input  logic [15:0]                   scr0_dout,
    input  logic [15:0]                   scr1_dout,
    input  logic [15:0]                   oram_dout,
    input  logic [7:0]                    c30_dout,
    output logic [7:0]                    cpu_din,
    output logic                          int_n,
    output logic                          cpu_rst,
    output logic                          flip,
    output logic                          srst,
    output logic [1:0]                    palbank,
    output logic [8:0]                    scr0_pos,
    output logic [8:0]                    scr1_pos,
    output logic [1:0]                    scr0_we,
    output logic [1:0]                    scr1_we,
    output logic [1:0]                    oram_we,
    output logic [paclan_pkg::ROM_AW-1:0] rom_addr,
    output logic                          rom_cs,
    output logic                          bus_busy,
    output logic                          c30_cs,
    output paclan_pkg::status_t           st_dout
);

    paclan_pkg::chip_sel_t cs;
    paclan_pkg::bank_reg_t bank_reg;
    logic [1:0]            byte_sel;
    logic                  ok_dly;
    logic                  kick;
    logic                  kick_l;

    assign kick     = cs.wdog & bus.cen_e;
    assign palbank  = bank_reg.palbank;
    assign rom_cs   = cs.rom;
    assign c30_cs   = cs.c30;
    assign bus_busy = cs.rom & ~ok_dly;

    // Banked window maps to the upper half of the ROM
    assign rom_addr = cs.banked ? {1'b1, bank_reg.bank, bus.addr[12:0]} : {1'b0, bus.addr};

    assign byte_sel = {bus.addr[0], ~bus.addr[0]};
    assign scr0_we  = {2{cs.scr0 & ~bus.rnw}} & byte_sel;
    assign scr1_we  = {2{cs.scr1 & ~bus.rnw}} & byte_sel;
    assign oram_we  = {2{cs.oram & ~bus.rnw}} & byte_sel;

    // Status shows the last kick
    always_ff @(posedge clk) begin
        if (rst) begin
            kick_l <= 1'b0;
        end else begin
            kick_l <= kick;
        end
    end

    assign st_dout = '{wdog: kick_l, zero: 4'd0, flip: flip, palbank: bank_reg.palbank};

    paclan_addr_dec u_addr_dec (
        .clk   ( clk   ),
        .rst   ( rst   ),
        .bus   ( bus   ),
        .lvbl  ( lvbl  ),
        .cs    ( cs    ),
        .int_n ( int_n ),
        .flip  ( flip  ),
        .srst  ( srst  )
    );

    paclan_ctrl_regs u_ctrl_regs (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .bus      ( bus      ),
        .cs       ( cs       ),
        .scr0_pos ( scr0_pos ),
        .scr1_pos ( scr1_pos ),
        .bank_reg ( bank_reg )
    );

    paclan_watchdog #(
        .WDOG_FRAMES ( WDOG_FRAMES ),
        .WDOG_PULSE  ( WDOG_PULSE  )
    ) u_watchdog (
        .clk     ( clk     ),
        .rst     ( rst     ),
        .lvbl    ( lvbl    ),
        .kick    ( kick    ),
        .cpu_rst ( cpu_rst )
    );

    paclan_busmux u_busmux (
        .clk       ( clk         ),
        .addr0     ( bus.addr[0] ),
        .cs        ( cs          ),
        .rom_ok    ( rom_ok      ),
        .scr0_dout ( scr0_dout   ),
        .scr1_dout ( scr1_dout   ),
        .oram_dout ( oram_dout   ),
        .c30_dout  ( c30_dout    ),
        .rom_data  ( rom_data    ),
        .ok_dly    ( ok_dly      ),
        .cpu_din   ( cpu_din     )
    );

endmodule

// ==== hdl/paclan_pkg.sv ====
////////////////////////////////////////////////////////////
// Shared types and address map for the main-CPU bus logic.
// Referenced by scoped name from every block of the subsystem.
////////////////////////////////////////////////////////////

package paclan_pkg;

    // Width of the ROM address seen by the SDRAM side
    localparam int ROM_AW = 17;

    // One CPU bus cycle as driven by the 6809 side
    typedef struct packed {
        logic [15:0] addr;
        logic        rnw;
        logic [ 7:0] dout;
        logic        cen_e;
    } main_bus_t;

    typedef struct packed {
        logic scr0;
        logic scr1;
        logic oram;
        logic scr0pos;
        logic scr1pos;
        logic basel;
        logic banked;
        logic rom;
        logic c30;
        logic wdog;
    } chip_sel_t;

    // Palette and ROM bank byte
    typedef struct packed {
        logic [2:0] unused;
        logic [1:0] palbank;
        logic [2:0] bank;
    } bank_reg_t;

    typedef struct packed {
        logic       wdog;
        logic [3:0] zero;
        logic       flip;
        logic [1:0] palbank;
    } status_t;

    // Address map as base and mask pairs
    localparam logic [15:0] SCR0_BASE    = 16'h0000, SCR0_MASK    = 16'hF000;
    localparam logic [15:0] SCR1_BASE    = 16'h1000, SCR1_MASK    = 16'hF000;
    // Object RAM window runs to 3FFF with the register area cut out of it
    localparam logic [15:0] ORAM_BASE    = 16'h2000, ORAM_MASK    = 16'hE000;
    localparam logic [15:0] SCR0POS_ADDR = 16'h3800, SCR0POS_MASK = 16'hFE00;
    localparam logic [15:0] SCR1POS_ADDR = 16'h3A00, SCR1POS_MASK = 16'hFE00;
    localparam logic [15:0] BASEL_ADDR   = 16'h3C00, BASEL_MASK   = 16'hFC00;
    localparam logic [15:0] BANKED_BASE  = 16'h4000, BANKED_MASK  = 16'hE000;
    localparam logic [15:0] C30_BASE     = 16'h6800, C30_MASK     = 16'hFC00;
    localparam logic [15:0] IRQ_ADDR     = 16'h7000, IRQ_MASK     = 16'hF800;
    localparam logic [15:0] FLIP_ADDR    = 16'h7800, FLIP_MASK    = 16'hF800;
    localparam logic [15:0] ROM_BASE     = 16'h8000, ROM_MASK     = 16'h8000;
    // Write-only latches sitting on top of the fixed ROM
    localparam logic [15:0] WDOG_ADDR    = 16'h8000, WDOG_MASK    = 16'hF800;
    localparam logic [15:0] SRST_ADDR    = 16'h8800, SRST_MASK    = 16'hF800;

    function automatic logic addr_hit(
        input logic [15:0] addr,
        input logic [15:0] base,
        input logic [15:0] mask
    );
        return (addr & mask) == base;
    endfunction

endpackage

// ==== hdl/paclan_watchdog.sv ====
////////////////////////////////////////////////////////////
// Frame watchdog. Counts VBL falling edges since the last
// kick and drives a fixed-length CPU reset pulse on expiry.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module paclan_watchdog #(
    parameter int unsigned WDOG_FRAMES = 8,
    parameter int unsigned WDOG_PULSE  = 16
) (
    input  logic clk,
    input  logic rst,
    input  logic lvbl,
    input  logic kick,
    output logic cpu_rst
);

    localparam int CW = $clog2(WDOG_FRAMES + 1);
    localparam int TW = $clog2(WDOG_PULSE + 1);
    localparam logic [CW-1:0] LAST_FRAME = CW'(WDOG_FRAMES - 1);
    localparam logic [TW-1:0] PULSE_LAST = TW'(WDOG_PULSE - 1);

    logic [CW-1:0] frames;
    logic [TW-1:0] timer;
    logic          lvbl_l;
    logic          vb_fall;

    assign vb_fall = lvbl_l & ~lvbl;

    always_ff @(posedge clk) begin
        if (rst) begin
            lvbl_l  <= 1'b0;
            frames  <= '0;
            timer   <= '0;
            cpu_rst <= 1'b0;
        end else begin
            lvbl_l <= lvbl;
            if (kick) begin
                frames <= '0;
            end else if (vb_fall) begin
                if (frames == LAST_FRAME) begin
                    frames  <= '0;
                    timer   <= PULSE_LAST;
                    cpu_rst <= 1'b1;
                end else begin
                    frames <= frames + 1'b1;
                end
            end
            // Pulse timer runs down to zero
            if (cpu_rst && !(vb_fall && !kick && frames == LAST_FRAME)) begin
                if (timer == '0) begin
                    cpu_rst <= 1'b0;
                end else begin
                    timer <= timer - 1'b1;
                end
            end
        end
    end

    a_pulse_len: assert property (@(posedge clk) disable iff (rst)
        $rose(cpu_rst) |-> cpu_rst [*WDOG_PULSE] ##1 !cpu_rst);

endmodule

// ==== sim.f ====
hdl/paclan_pkg.sv
hdl/paclan_addr_dec.sv
hdl/paclan_ctrl_regs.sv
hdl/paclan_watchdog.sv
hdl/paclan_busmux.sv
hdl/paclan_main.sv
testbench/paclan_main_tb.sv

// ==== testbench/paclan_main_tb.sv ====
////////////////////////////////////////////////////////////
// Testbench for the main-CPU bus subsystem. Plays the CPU,
// predicts outputs from the address map and compares them.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module paclan_main_tb;

    localparam int WDOG_FRAMES = 8;
    localparam int WDOG_PULSE  = 16;
    localparam int MAX_CYCLES  = 3000;
    localparam int AW          = paclan_pkg::ROM_AW;

    typedef struct packed {
        logic [7:0]    din;
        logic [1:0]    scr0_we;
        logic [1:0]    scr1_we;
        logic [1:0]    oram_we;
        logic          rom_cs;
        logic          c30_cs;
        logic [AW-1:0] rom_addr;
    } expect_t;

    logic clk = 1'b0;
    logic rst;
    paclan_pkg::main_bus_t bus;
    logic lvbl, rom_ok;
    logic [7:0] rom_data, c30_dout, cpu_din;
    logic [15:0] scr0_dout, scr1_dout, oram_dout;
    logic int_n, cpu_rst, flip, srst, rom_cs, bus_busy, c30_cs;
    logic [1:0] palbank, scr0_we, scr1_we, oram_we;
    logic [8:0] scr0_pos, scr1_pos;
    logic [AW-1:0] rom_addr;
    paclan_pkg::status_t st_dout;

    // Shadow copies of the DUT state
    logic [7:0] sh_bank;
    logic [8:0] sh_scr0, sh_scr1;
    logic sh_flip, sh_srst, sh_irq_en, sh_int_n;
    logic [31:0] lfsr = 32'h6046;
    int errors = 0;
    int cycles = 0;
    int edges_since_kick = 0;
    int rst_len = 0;
    int pulses[$];
    expect_t exp_v;

    paclan_main #(
        .WDOG_FRAMES ( WDOG_FRAMES ),
        .WDOG_PULSE  ( WDOG_PULSE  )
    ) u_paclan_main (
        .clk(clk), .rst(rst), .bus(bus), .lvbl(lvbl), .rom_ok(rom_ok),
        .rom_data(rom_data), .scr0_dout(scr0_dout), .scr1_dout(scr1_dout),
        .oram_dout(oram_dout), .c30_dout(c30_dout), .cpu_din(cpu_din),
        .int_n(int_n), .cpu_rst(cpu_rst), .flip(flip), .srst(srst),
        .palbank(palbank), .scr0_pos(scr0_pos), .scr1_pos(scr1_pos),
        .scr0_we(scr0_we), .scr1_we(scr1_we), .oram_we(oram_we),
        .rom_addr(rom_addr), .rom_cs(rom_cs), .bus_busy(bus_busy),
        .c30_cs(c30_cs), .st_dout(st_dout)
    );

    always #10 clk = ~clk;

    // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic in_rom(input logic [15:0] a);
        return a[15] || (a >= 16'h4000 && a < 16'h6000);
    endfunction

    // Expected read byte, write enables, selects and ROM address
    function automatic expect_t ref_read(input logic [15:0] a, input logic rnw);
        expect_t e;
        logic [1:0] we;
        we = rnw ? 2'b00 : (a[0] ? 2'b10 : 2'b01);
        e = '0;
        e.din = 8'hFF;
        if (a < 16'h1000) begin
            e.din = a[0] ? scr0_dout[15:8] : scr0_dout[7:0];
            e.scr0_we = we;
        end else if (a < 16'h2000) begin
            e.din = a[0] ? scr1_dout[15:8] : scr1_dout[7:0];
            e.scr1_we = we;
        end else if (a < 16'h3800) begin
            e.din = a[0] ? oram_dout[15:8] : oram_dout[7:0];
            e.oram_we = we;
        end else if (in_rom(a)) begin
            e.din = rom_data;
        end else if (a >= 16'h6800 && a < 16'h6C00) begin
            e.din = c30_dout;
        end
        e.rom_cs = in_rom(a);
        e.c30_cs = (a >= 16'h6800 && a < 16'h6C00);
        if (a >= 16'h4000 && a < 16'h6000) begin
            e.rom_addr = {1'b1, sh_bank[2:0], a[12:0]};
        end else begin
            e.rom_addr = {1'b0, a};
        end
        return e;
    endfunction

    task automatic expect_eq(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
        assert (got === exp) else begin
            $display("[FAIL] %0t ns: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // Compare on every strobe cycle at mid-cycle where all is settled
    always @(posedge clk) begin
        #5;
        if (!rst && bus.cen_e) begin
            exp_v = ref_read(bus.addr, bus.rnw);
            expect_eq(cpu_din, exp_v.din, "cpu_din");
            expect_eq(scr0_we, exp_v.scr0_we, "scr0_we");
            expect_eq(scr1_we, exp_v.scr1_we, "scr1_we");
            expect_eq(oram_we, exp_v.oram_we, "oram_we");
            expect_eq(rom_cs, exp_v.rom_cs, "rom_cs");
            expect_eq(c30_cs, exp_v.c30_cs, "c30_cs");
            expect_eq(rom_addr, exp_v.rom_addr, "rom_addr");
        end
        if (!rst) begin
            assert (!bus_busy || in_rom(bus.addr)) else begin
                $display("[FAIL] %0t ns: bus_busy high without a ROM select", $time);
                errors++;
            end
        end
    end

    task automatic check_regs();
        expect_eq(scr0_pos, sh_scr0, "scr0_pos");
        expect_eq(scr1_pos, sh_scr1, "scr1_pos");
        expect_eq(palbank, sh_bank[4:3], "palbank");
        expect_eq(st_dout[6:0], {4'd0, sh_flip, sh_bank[4:3]}, "status");
        expect_eq(flip, sh_flip, "flip");
        expect_eq(srst, sh_srst, "srst");
        expect_eq(int_n, sh_int_n, "int_n");
    endtask

    task automatic shadow_write(input logic [15:0] a, input logic [7:0] d);
        if (a >= 16'h3800 && a < 16'h3A00) sh_scr0 = {a[0], d};
        if (a >= 16'h3A00 && a < 16'h3C00) sh_scr1 = {a[0], d};
        if (a >= 16'h3C00 && a < 16'h4000) sh_bank = d;
        if (a >= 16'h7000 && a < 16'h7800) begin
            sh_int_n = 1'b1;
            sh_irq_en = a[0];
        end
        if (a >= 16'h7800 && a < 16'h8000) sh_flip = a[0];
        if (a >= 16'h8800 && a < 16'h9000) sh_srst = ~a[0];
        if (a >= 16'h8000 && a < 16'h8800) edges_since_kick = 0;
    endtask

    // One strobed CPU cycle with fresh data on every source
    task automatic cpu_access(input logic [15:0] a, input logic rnw, input logic [7:0] d);
        @(negedge clk);
        rom_data  = rand_bits(8);
        c30_dout  = rand_bits(8);
        scr0_dout = rand_bits(16);
        scr1_dout = rand_bits(16);
        oram_dout = rand_bits(16);
        bus = '{addr: a, rnw: rnw, dout: d, cen_e: 1'b1};
        @(posedge clk);
        #1;
        if (!rnw) shadow_write(a, d);
        #4;
        check_regs();
        @(negedge clk);
        bus.cen_e = 1'b0;
    endtask

    // 64-cycle frame with VBL starting at its first cycle
    task automatic run_frame(input logic kick);
        if (kick) begin
            cpu_access(16'h8000, 1'b0, 8'h00);
            expect_eq(st_dout.wdog, 1'b1, "status wdog bit");
        end
        @(negedge clk);
        lvbl = 1'b0;
        edges_since_kick++;
        if (sh_irq_en) sh_int_n = 1'b0;
        @(posedge clk);
        #5;
        expect_eq(int_n, sh_int_n, "int_n after VBL");
        expect_eq(st_dout.wdog, 1'b0, "status wdog bit idle");
        repeat (31) @(negedge clk);
        lvbl = 1'b1;
        repeat (30) @(negedge clk);
    endtask

    // Pulse monitor for the watchdog reset
    always @(negedge clk) begin
        if (rst) begin
            rst_len = 0;
        end else if (cpu_rst) begin
            if (rst_len == 0) expect_eq(edges_since_kick, WDOG_FRAMES, "frames to expiry");
            rst_len++;
        end else if (rst_len != 0) begin
            pulses.push_back(rst_len);
            rst_len = 0;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, run did not finish", cycles);
            $display("tests failed");
            $finish;
        end
    end

    initial begin
        logic [15:0] a;
        int wait_n;
        rst = 1'b1;
        bus = '0;
        lvbl = 1'b1;
        rom_ok = 1'b1;
        rom_data = '0;
        c30_dout = '0;
        scr0_dout = '0;
        scr1_dout = '0;
        oram_dout = '0;
        sh_bank = '0;
        sh_scr0 = '0;
        sh_scr1 = '0;
        sh_flip = 1'b0;
        sh_srst = 1'b0;
        sh_irq_en = 1'b0;
        sh_int_n = 1'b1;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        check_regs();

        // Random reads and writes over the whole map
        repeat (150) cpu_access(rand_bits(16), rand_bits(1), rand_bits(8));

        // Scroll and bank registers, then banked and fixed ROM reads
        repeat (8) begin
            cpu_access(16'h3800 | rand_bits(9), 1'b0, rand_bits(8));
            cpu_access(16'h3A00 | rand_bits(9), 1'b0, rand_bits(8));
            cpu_access(16'h3C00 | rand_bits(10), 1'b0, rand_bits(8));
            cpu_access(16'h4000 | rand_bits(13), 1'b1, 8'h00);
            cpu_access(16'h8000 | rand_bits(15), 1'b1, 8'h00);
        end

        // ROM not ready holds the bus
        repeat (6) begin
            wait_n = 1 + rand_bits(3);
            a = 16'h8000 | rand_bits(15);
            // Not ready while the bus sits outside the ROM
            @(negedge clk);
            rom_ok = 1'b0;
            bus = '{addr: a & 16'h3FFF, rnw: 1'b1, dout: 8'h00, cen_e: 1'b0};
            @(posedge clk);
            #5;
            expect_eq(bus_busy, 1'b0, "bus_busy outside the ROM");
            @(negedge clk);
            bus = '{addr: a, rnw: 1'b1, dout: 8'h00, cen_e: 1'b1};
            repeat (wait_n) begin
                @(posedge clk);
                #5;
                expect_eq(bus_busy, 1'b1, "bus_busy while ROM waits");
            end
            @(negedge clk);
            rom_ok = 1'b1;
            #1;
            expect_eq(bus_busy, 1'b1, "bus_busy as rom_ok rises");
            @(posedge clk);
            #5;
            expect_eq(bus_busy, 1'b0, "bus_busy after ok delay");
            @(negedge clk);
            bus.cen_e = 1'b0;
        end

        // VBL interrupt enabled, acknowledged, then disabled
        cpu_access(16'h7001, 1'b0, 8'h00);
        run_frame(1'b1);
        check_regs();
        cpu_access(16'h7000, 1'b0, 8'h00);
        run_frame(1'b1);

        // Flip and sub-CPU reset latches
        cpu_access(16'h7801, 1'b0, 8'h00);
        cpu_access(16'h8800, 1'b0, 8'h00);
        cpu_access(16'h7800, 1'b0, 8'h00);
        cpu_access(16'h8801, 1'b0, 8'h00);

        // Watchdog kicked every frame, then left alone
        repeat (8) run_frame(1'b1);
        expect_eq(pulses.size(), 0, "reset pulses while kicked");
        cpu_access(16'h8000, 1'b0, 8'h00);
        repeat (WDOG_FRAMES) run_frame(1'b0);
        expect_eq(pulses.size(), 1, "reset pulses after expiry");
        if (pulses.size() > 0) expect_eq(pulses[0], WDOG_PULSE, "reset pulse length");

        $display("cycles: %0d, errors: %0d", cycles, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
